// ==== list.f ====
+incdir+dv
hdl/h2c_pkg.sv
hdl/h2c_regs.sv
hdl/h2c_requester.sv
hdl/h2c_cpl_buffer.sv
hdl/h2c_fwft_out.sv
hdl/h2c_top.sv
dv/tb_h2c.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_h2c -o Vtb_h2c

# the simulation exits non-zero on failure, the log decides the result
./obj_dir/Vtb_h2c > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// ==== dv/tb_h2c_checks.svh ====
`ifndef TB_H2C_CHECKS_SVH
`define TB_H2C_CHECKS_SVH

// ends the run at the first error
task automatic stop_run();
   $display("** FAIL **");
   $fatal(1, "run stopped at first error");
endtask

task automatic fail_now(input string why);
   $display("ERROR %s", why);
   stop_run();
endtask

task automatic compare_req(input string name, input h2c_pkg::rd_req_t exp,
                           input h2c_pkg::rd_req_t act);
   if (act !== exp)
   begin
      $display("MISMATCH %s addr exp %h act %h tag exp %h act %h",
               name, exp.addr, act.addr, exp.tag, act.tag);
      stop_run();
   end
endtask

task automatic compare_word(input string name, input logic [63:0] exp, input logic [63:0] act);
   if (act !== exp)
   begin
      $display("MISMATCH %s exp %h act %h", name, exp, act);
      stop_run();
   end
endtask

// read data of a register access
task automatic compare_reg(input string name, input logic [63:0] exp,
                           input h2c_pkg::wb_rsp_t act);
   if (act.dat !== exp)
   begin
      $display("MISMATCH %s exp %h act %h", name, exp, act.dat);
      stop_run();
   end
endtask

task automatic compare_irq(input logic exp_stop, input logic exp_int,
                           input logic act_stop, input logic act_int);
   if (act_stop !== exp_stop || act_int !== exp_int)
   begin
      $display("MISMATCH irq_stop exp %h act %h irq_int exp %h act %h",
               exp_stop, act_stop, exp_int, act_int);
      stop_run();
   end
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
   if (act !== exp)
   begin
      $display("MISMATCH %s exp %h act %h", name, exp, act);
      stop_run();
   end
endtask

`endif

// ==== dv/tb_h2c.sv ====
`timescale 1ns/1ps

module tb_h2c;

   localparam int CLK_NS = 40;
   localparam int TEST_BLOCKS = 24;
   localparam int TIMEOUT_NS = TEST_BLOCKS * h2c_pkg::BLOCK_WORDS * 4 * CLK_NS + 40000;
   localparam int SB_WORDS = 16 * h2c_pkg::BLOCK_WORDS;

   logic clock;
   logic reset;
   h2c_pkg::wb_req_t wb_req;
   h2c_pkg::wb_rsp_t wb_rsp;
   h2c_pkg::rd_req_t rd_req;
   logic rr_valid;
   logic rr_ready;
   h2c_pkg::rd_cpl_t rd_cpl;
   logic [63:0] fifo_data;
   logic fifo_valid;
   logic fifo_pop;
   logic irq_stop;
   logic irq_int;

   // host and consumer model
   int seed = 30;
   int next_blk;
   int exp_word;
   h2c_pkg::rd_cpl_t cpl_q[$];
   logic [63:0] sb [SB_WORDS];
   logic [63:0] pt_bytes [h2c_pkg::PT_ENTRIES];
   bit ready_en;
   bit answer_en;
   bit pop_en;
   bit pop_random;

   h2c_top dut (.*);

   `include "tb_h2c_checks.svh"

   initial
   begin
      clock = 1'b0;
      forever #(CLK_NS / 2) clock = ~clock;
   end

   initial
   begin
      #(TIMEOUT_NS);
      fail_now("timeout, the tests did not finish in time");
   end

   function automatic logic [63:0] blk_bytes(input int blk);
      return 64'(blk) << h2c_pkg::BLK_SHIFT;
   endfunction

   // page base plus block offset inside its 4096-block page
   function automatic logic [63:0] expected_addr(input int blk);
      return pt_bytes[blk / 4096] + (64'(blk % 4096) << 9);
   endfunction

   // 64 completions with random data and index 63 last
   task automatic answer_block(input int blk, input bit shuffle);
      h2c_pkg::rd_cpl_t c;
      int idx;
      for (int i = 0; i < h2c_pkg::BLOCK_WORDS; i++)
      begin
         idx = i;
         if (shuffle && i < 63)
            idx = (i * 5 + 3) % 63;
         c.valid = 1'b1;
         c.tag = 8'(blk % h2c_pkg::SLOTS);
         c.index = 6'(idx);
         c.data = {32'($random(seed)), 32'($random(seed))};
         sb[blk * h2c_pkg::BLOCK_WORDS + idx] = c.data;
         cpl_q.push_back(c);
      end
   endtask

   task automatic capture_request();
      h2c_pkg::rd_req_t exp;
      exp.addr = expected_addr(next_blk);
      exp.tag = 8'(next_blk % h2c_pkg::SLOTS);
      compare_req("rd_req", exp, rd_req);
      if (answer_en)
         answer_block(next_blk, 1'b0);
      next_blk++;
   endtask

   // drive on the falling edge and log transfers of the next rising edge
   task automatic cycle();
      logic pop;
      @(negedge clock);
      rd_cpl = '0;
      if (cpl_q.size() > 0)
         rd_cpl = cpl_q.pop_front();
      rr_ready = ready_en;
      if (rr_valid && ready_en)
         capture_request();
      pop = pop_en && (!pop_random || ($random(seed) % 2 == 0));
      fifo_pop = pop;
      if (fifo_valid && pop)
      begin
         compare_word("fifo_data", sb[exp_word], fifo_data);
         exp_word++;
      end
   endtask

   task automatic wait_words(input int n);
      while (exp_word < n)
         cycle();
   endtask

   task automatic drain();
      while (cpl_q.size() > 0)
         cycle();
      repeat (4) cycle();
   endtask

   // classic cycle, ack exactly one clock after stb
   task automatic wb_access(input logic we, input logic [12:0] adr, input logic [63:0] wdat,
                            output h2c_pkg::wb_rsp_t rsp);
      cycle();
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      compare_flag("wb_rsp.ack", 1'b0, wb_rsp.ack);
      cycle();
      compare_flag("wb_rsp.ack", 1'b1, wb_rsp.ack);
      rsp = wb_rsp;
      wb_req = '0;
      cycle();
      compare_flag("wb_rsp.ack", 1'b0, wb_rsp.ack);
   endtask

   task automatic write_reg(input logic [12:0] adr, input logic [63:0] value);
      h2c_pkg::wb_rsp_t rsp;
      wb_access(1'b1, adr, value, rsp);
   endtask

   task automatic read_reg(input string name, input logic [12:0] adr, input logic [63:0] exp);
      h2c_pkg::wb_rsp_t rsp;
      wb_access(1'b0, adr, 64'd0, rsp);
      compare_reg(name, exp, rsp);
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      ready_en = 1'b0;
      answer_en = 1'b0;
      pop_en = 1'b0;
      pop_random = 1'b0;
      next_blk = 0;
      exp_word = 0;
      cpl_q.delete();
      repeat (3) cycle();
      reset = 1'b0;
   endtask

   task automatic test_registers();
      apply_reset();
      read_reg("status", h2c_pkg::REG_STATUS, 64'd0);
      compare_flag("rr_valid", 1'b0, rr_valid);
      compare_irq(1'b0, 1'b0, irq_stop, irq_int);
      pt_bytes[0] = 64'h0012_3456_78e0_0000;
      pt_bytes[1] = 64'h8000_0000_0020_0000;
      write_reg(h2c_pkg::REG_PT_BASE, pt_bytes[0]);
      write_reg(13'(h2c_pkg::REG_PT_BASE + 1), pt_bytes[1]);
      write_reg(h2c_pkg::REG_INT, blk_bytes(5));
      write_reg(h2c_pkg::REG_STOP, blk_bytes(7));
      read_reg("pt0", h2c_pkg::REG_PT_BASE, pt_bytes[0]);
      read_reg("pt1", 13'(h2c_pkg::REG_PT_BASE + 1), pt_bytes[1]);
      read_reg("int", h2c_pkg::REG_INT, blk_bytes(5));
      read_reg("stop", h2c_pkg::REG_STOP, blk_bytes(7));
   endtask

   task automatic test_requests();
      h2c_pkg::rd_req_t exp;
      apply_reset();
      write_reg(h2c_pkg::REG_STOP, blk_bytes(3));
      ready_en = 1'b1;
      while (next_blk < 1)
         cycle();
      // back-pressure on block 1
      ready_en = 1'b0;
      exp.addr = expected_addr(1);
      exp.tag = 8'd1;
      repeat (3)
      begin
         cycle();
         compare_flag("rr_valid", 1'b1, rr_valid);
         compare_req("rd_req", exp, rd_req);
      end
      ready_en = 1'b1;
      while (next_blk < 3)
         cycle();
      repeat (8)
      begin
         cycle();
         compare_flag("rr_valid", 1'b0, rr_valid);
      end
   endtask

   task automatic test_in_order();
      apply_reset();
      ready_en = 1'b1;
      answer_en = 1'b1;
      pop_en = 1'b1;
      write_reg(h2c_pkg::REG_STOP, blk_bytes(4));
      wait_words(4 * h2c_pkg::BLOCK_WORDS);
      repeat (8)
      begin
         cycle();
         compare_flag("fifo_valid", 1'b0, fifo_valid);
      end
   endtask

   task automatic test_out_of_order();
      apply_reset();
      ready_en = 1'b1;
      pop_en = 1'b1;
      write_reg(h2c_pkg::REG_STOP, blk_bytes(3));
      while (next_blk < 3)
         cycle();
      answer_block(0, 1'b0);
      answer_block(2, 1'b1);
      wait_words(h2c_pkg::BLOCK_WORDS);
      drain();
      // block 2 is complete but waits for block 1
      compare_flag("fifo_valid", 1'b0, fifo_valid);
      answer_block(1, 1'b1);
      wait_words(3 * h2c_pkg::BLOCK_WORDS);
   endtask

   task automatic test_window();
      apply_reset();
      ready_en = 1'b1;
      answer_en = 1'b1;
      write_reg(h2c_pkg::REG_STOP, blk_bytes(10));
      drain();
      repeat (16) cycle();
      if (next_blk > h2c_pkg::MAX_AHEAD)
         fail_now("more than MAX_AHEAD blocks requested with nothing read out");
      pop_en = 1'b1;
      pop_random = 1'b1;
      while (exp_word < 10 * h2c_pkg::BLOCK_WORDS)
      begin
         cycle();
         // at most two words sit between fetch and pop
         if (next_blk > (exp_word + 2) / h2c_pkg::BLOCK_WORDS + h2c_pkg::MAX_AHEAD)
            fail_now("request window exceeded while popping");
      end
   endtask

   task automatic test_interrupts();
      apply_reset();
      ready_en = 1'b1;
      write_reg(h2c_pkg::REG_INT, blk_bytes(2));
      write_reg(h2c_pkg::REG_STOP, blk_bytes(4));
      while (next_blk < 4)
         cycle();
      compare_irq(1'b0, 1'b0, irq_stop, irq_int);
      for (int b = 0; b < 4; b++)
      begin
         answer_block(b, 1'b0);
         drain();
         read_reg("status", h2c_pkg::REG_STATUS, blk_bytes(b + 1));
         compare_irq(b + 1 == 4, b + 1 == 2, irq_stop, irq_int);
      end
      pop_en = 1'b1;
      wait_words(4 * h2c_pkg::BLOCK_WORDS);
   endtask

   initial
   begin
      reset = 1'b1;
      wb_req = '0;
      rr_ready = 1'b0;
      rd_cpl = '0;
      fifo_pop = 1'b0;
      test_registers();
      test_requests();
      test_in_order();
      test_out_of_order();
      test_window();
      test_interrupts();
      $display("** PASS **");
      $finish;
   end

endmodule

// ==== hdl/h2c_top.sv ====
`timescale 1ns/1ps

module h2c_top
(
   input  logic              clock,
   input  logic              reset,
   input  h2c_pkg::wb_req_t  wb_req,
   output h2c_pkg::wb_rsp_t  wb_rsp,
   output h2c_pkg::rd_req_t  rd_req,
   output logic              rr_valid,
   input  logic              rr_ready,
   input  h2c_pkg::rd_cpl_t  rd_cpl,
   output logic [63:0]       fifo_data,
   output logic              fifo_valid,
   input  logic              fifo_pop,
   output logic              irq_stop,
   output logic              irq_int
);

   logic [h2c_pkg::PT_AW-1:0] pt_index;
   h2c_pkg::pt_entry_t pt_entry;
   h2c_pkg::blk_ptr_t stop_ptr;
   h2c_pkg::blk_ptr_t int_ptr;
   h2c_pkg::blk_ptr_t wr_ptr;
   h2c_pkg::blk_ptr_t rd_blk;
   logic [h2c_pkg::BUF_AW-1:0] rd_addr;
   logic [63:0] rd_data;

   h2c_regs decode
   (
      .clock    (clock),
      .reset    (reset),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .pt_index (pt_index),
      .pt_entry (pt_entry),
      .stop_ptr (stop_ptr),
      .int_ptr  (int_ptr),
      .wr_ptr   (wr_ptr)
   );

   h2c_requester execute
   (
      .clock    (clock),
      .reset    (reset),
      .stop_ptr (stop_ptr),
      .rd_blk   (rd_blk),
      .pt_index (pt_index),
      .pt_entry (pt_entry),
      .rd_req   (rd_req),
      .rr_valid (rr_valid),
      .rr_ready (rr_ready)
   );

   h2c_cpl_buffer result
   (
      .clock    (clock),
      .reset    (reset),
      .rd_cpl   (rd_cpl),
      .stop_ptr (stop_ptr),
      .int_ptr  (int_ptr),
      .wr_ptr   (wr_ptr),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .irq_stop (irq_stop),
      .irq_int  (irq_int)
   );

   h2c_fwft_out stream
   (
      .clock      (clock),
      .reset      (reset),
      .wr_ptr     (wr_ptr),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .fifo_data  (fifo_data),
      .fifo_valid (fifo_valid),
      .fifo_pop   (fifo_pop),
      .rd_blk     (rd_blk)
   );

endmodule

// ==== hdl/h2c_fwft_out.sv ====
`timescale 1ns/1ps

module h2c_fwft_out
(
   input  logic                       clock,
   input  logic                       reset,
   input  h2c_pkg::blk_ptr_t          wr_ptr,
   output logic [h2c_pkg::BUF_AW-1:0] rd_addr,
   input  logic [63:0]                rd_data,
   output logic [63:0]                fifo_data,
   output logic                       fifo_valid,
   input  logic                       fifo_pop,
   output h2c_pkg::blk_ptr_t          rd_blk
);

   h2c_pkg::word_ptr_t rd_word;
   h2c_pkg::word_ptr_t wr_word;
   h2c_pkg::word_ptr_t held_word;
   logic a_valid;
   logic b_valid;
   logic a_cken;
   logic b_cken;
   logic [63:0] b_data;

   assign wr_word = {wr_ptr, {h2c_pkg::WORD_AW{1'b0}}};
   assign held_word = rd_word - 1'b1;
   assign rd_blk = rd_word[h2c_pkg::WORD_AW +: h2c_pkg::BLK_W];

   // fetch stage lives in the buffer's read register
   assign a_cken = (rd_word != wr_word) && (!a_valid || !b_valid || fifo_pop);
   assign b_cken = a_valid && (!b_valid || fifo_pop);

   // on a stall keep reading the word held in the fetch stage
   assign rd_addr = a_cken ? rd_word[h2c_pkg::BUF_AW-1:0] : held_word[h2c_pkg::BUF_AW-1:0];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         rd_word <= '0;
         a_valid <= 1'b0;
         b_valid <= 1'b0;
      end
      else
      begin
         if (a_cken)
         begin
            rd_word <= rd_word + 1'b1;
         end
         a_valid <= a_cken || (a_valid && !b_cken);
         b_valid <= b_cken || (b_valid && !fifo_pop);
      end
   end

   always_ff @(posedge clock)
   begin
      if (b_cken)
      begin
         b_data <= rd_data;
      end
   end

   assign fifo_data = b_data;
   assign fifo_valid = b_valid;

endmodule

// ==== hdl/h2c_cpl_buffer.sv ====
`timescale 1ns/1ps

module h2c_cpl_buffer
(
   input  logic                       clock,
   input  logic                       reset,
   input  h2c_pkg::rd_cpl_t           rd_cpl,
   input  h2c_pkg::blk_ptr_t          stop_ptr,
   input  h2c_pkg::blk_ptr_t          int_ptr,
   output h2c_pkg::blk_ptr_t          wr_ptr,
   input  logic [h2c_pkg::BUF_AW-1:0] rd_addr,
   output logic [63:0]                rd_data,
   output logic                       irq_stop,
   output logic                       irq_int
);

   logic [63:0] mem [h2c_pkg::SLOTS * h2c_pkg::BLOCK_WORDS];
   logic [h2c_pkg::SLOTS-1:0] filled;
   logic accept;
   logic cpl_last;
   logic [h2c_pkg::SLOT_AW-1:0] cpl_slot;
   logic [h2c_pkg::BUF_AW-1:0] wr_addr;
   logic [h2c_pkg::SLOT_AW-1:0] wr_slot;
   logic advance;

   // tags of 8 and above are not ours
   assign accept = rd_cpl.valid && (rd_cpl.tag < 8'(h2c_pkg::SLOTS));
   assign cpl_slot = rd_cpl.tag[h2c_pkg::SLOT_AW-1:0];
   assign wr_addr = {cpl_slot, rd_cpl.index};
   assign cpl_last = accept && (rd_cpl.index == 6'(h2c_pkg::BLOCK_WORDS - 1));

   assign wr_slot = wr_ptr[h2c_pkg::SLOT_AW-1:0];
   assign advance = filled[wr_slot];

   always_ff @(posedge clock)
   begin
      if (accept)
      begin
         mem[wr_addr] <= rd_cpl.data;
      end
      rd_data <= mem[rd_addr];
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         filled <= '0;
         wr_ptr <= '0;
      end
      else
      begin
         for (int i = 0; i < h2c_pkg::SLOTS; i++)
         begin
            // a new fill wins over the release
            if (cpl_last && (cpl_slot == i))
            begin
               filled[i] <= 1'b1;
            end
            else if (advance && (wr_slot == i))
            begin
               filled[i] <= 1'b0;
            end
         end
         if (advance)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   // zero pointer keeps the interrupt idle
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         irq_stop <= 1'b0;
         irq_int <= 1'b0;
      end
      else
      begin
         irq_stop <= (wr_ptr == stop_ptr) && (stop_ptr != '0);
         irq_int <= (wr_ptr == int_ptr) && (int_ptr != '0);
      end
   end

endmodule

// ==== hdl/h2c_requester.sv ====
`timescale 1ns/1ps

module h2c_requester
(
   input  logic                      clock,
   input  logic                      reset,
   input  h2c_pkg::blk_ptr_t         stop_ptr,
   input  h2c_pkg::blk_ptr_t         rd_blk,
   output logic [h2c_pkg::PT_AW-1:0] pt_index,
   input  h2c_pkg::pt_entry_t        pt_entry,
   output h2c_pkg::rd_req_t          rd_req,
   output logic                      rr_valid,
   input  logic                      rr_ready
);

   h2c_pkg::blk_ptr_t req_ptr;
   h2c_pkg::blk_ptr_t req_next;
   h2c_pkg::blk_ptr_t ahead;
   logic take;
   logic below_stop;
   logic in_window;

   // blocks already in flight past the reader
   assign ahead = req_ptr - rd_blk;
   assign below_stop = req_ptr != stop_ptr;
   assign in_window = ahead < h2c_pkg::blk_ptr_t'(h2c_pkg::MAX_AHEAD);

   assign rr_valid = below_stop && in_window;
   assign take = rr_valid && rr_ready;

   assign req_next = take ? req_ptr + 1'b1 : req_ptr;

   // lookup is registered, so index with the next pointer
   assign pt_index = req_next[h2c_pkg::BLK_W-1 -: h2c_pkg::PT_AW];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         req_ptr <= '0;
      end
      else
      begin
         req_ptr <= req_next;
      end
   end

   assign rd_req.addr = {pt_entry,
                         req_ptr[h2c_pkg::PAGE_AW-1:0],
                         {h2c_pkg::BLK_SHIFT{1'b0}}};

   // tag picks the buffer slot
   assign rd_req.tag = 8'(req_ptr[h2c_pkg::SLOT_AW-1:0]);

endmodule

// ==== hdl/h2c_regs.sv ====
`timescale 1ns/1ps

module h2c_regs
(
   input  logic                      clock,
   input  logic                      reset,
   input  h2c_pkg::wb_req_t          wb_req,
   output h2c_pkg::wb_rsp_t          wb_rsp,
   input  logic [h2c_pkg::PT_AW-1:0] pt_index,
   output h2c_pkg::pt_entry_t        pt_entry,
   output h2c_pkg::blk_ptr_t         stop_ptr,
   output h2c_pkg::blk_ptr_t         int_ptr,
   input  h2c_pkg::blk_ptr_t         wr_ptr
);

   h2c_pkg::pt_entry_t page_table [h2c_pkg::PT_ENTRIES];
   logic ack_q;
   logic [63:0] dat_q;
   logic access;
   logic do_write;
   logic hit_status;
   logic hit_stop;
   logic hit_int;
   logic hit_pt;
   logic [h2c_pkg::PT_AW-1:0] pt_sel;
   logic [63:0] rd_value;

   // one access per stb and ack in the following cycle
   assign access = wb_req.cyc && wb_req.stb && !ack_q;
   assign do_write = access && wb_req.we;

   assign hit_status = wb_req.adr == h2c_pkg::REG_STATUS;
   assign hit_stop = wb_req.adr == h2c_pkg::REG_STOP;
   assign hit_int = wb_req.adr == h2c_pkg::REG_INT;
   assign hit_pt = (wb_req.adr & ~13'(h2c_pkg::PT_ENTRIES - 1)) == h2c_pkg::REG_PT_BASE;
   assign pt_sel = wb_req.adr[h2c_pkg::PT_AW-1:0];

   // pointers are byte offsets on the bus
   always_comb
   begin
      rd_value = '0;
      if (hit_status)
      begin
         rd_value = 64'({wr_ptr, {h2c_pkg::BLK_SHIFT{1'b0}}});
      end
      else if (hit_stop)
      begin
         rd_value = 64'({stop_ptr, {h2c_pkg::BLK_SHIFT{1'b0}}});
      end
      else if (hit_int)
      begin
         rd_value = 64'({int_ptr, {h2c_pkg::BLK_SHIFT{1'b0}}});
      end
      else if (hit_pt)
      begin
         rd_value = {page_table[pt_sel], 21'd0};
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         ack_q <= 1'b0;
         stop_ptr <= '0;
         int_ptr <= '0;
      end
      else
      begin
         ack_q <= access;
         if (do_write && hit_stop)
         begin
            stop_ptr <= wb_req.dat[h2c_pkg::BLK_SHIFT +: h2c_pkg::BLK_W];
         end
         if (do_write && hit_int)
         begin
            int_ptr <= wb_req.dat[h2c_pkg::BLK_SHIFT +: h2c_pkg::BLK_W];
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (access)
      begin
         dat_q <= rd_value;
      end
      if (do_write && hit_pt)
      begin
         page_table[pt_sel] <= wb_req.dat[63:21];
      end
      // lookup port for the requester
      pt_entry <= page_table[pt_index];
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = dat_q;

endmodule

// ==== hdl/h2c_pkg.sv ====
package h2c_pkg;

   // block pointer width for 512-byte blocks
   localparam int BLK_W = 17;
   localparam int BLOCK_WORDS = 64;
   localparam int WORD_AW = 6;

   // completion buffer geometry
   localparam int SLOTS = 8;
   localparam int SLOT_AW = 3;
   localparam int BUF_AW = SLOT_AW + WORD_AW;

   // each page of the table covers 4096 blocks
   localparam int PT_ENTRIES = 32;
   localparam int PT_AW = 5;
   localparam int PAGE_AW = 12;

   // blocks requested but not yet read out
   localparam int MAX_AHEAD = 6;

   // byte offset of the block number in register data and addresses
   localparam int BLK_SHIFT = 9;

   typedef logic [BLK_W-1:0] blk_ptr_t;
   typedef logic [BLK_W+WORD_AW-1:0] word_ptr_t;

   // page base holds byte address bits 63 to 21
   typedef logic [42:0] pt_entry_t;

   typedef enum logic [12:0]
   {
      REG_STATUS  = 13'd0,
      REG_STOP    = 13'd6,
      REG_INT     = 13'd7,
      REG_PT_BASE = 13'd64
   } reg_addr_e;

   typedef struct packed
   {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [12:0] adr;
      logic [63:0] dat;
   } wb_req_t;

   typedef struct packed
   {
      logic        ack;
      logic [63:0] dat;
   } wb_rsp_t;

   typedef struct packed
   {
      logic [63:0] addr;
      logic [7:0]  tag;
   } rd_req_t;

   typedef struct packed
   {
      logic        valid;
      logic [7:0]  tag;
      logic [5:0]  index;
      logic [63:0] data;
   } rd_cpl_t;

endpackage
